// File: Makefile
TOP = tb_mem_hierarchy

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

// File: cache_controller/cache_controller.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_controller
	import cache_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_i_acc,      // Fetch active
	input  logic                    i_d_acc,      // Data access active
	input  logic                    i_write,      // Data access is a store
	input  logic [`ADDR_W-1:0]      i_i_addr,
	input  logic [`ADDR_W-1:0]      i_d_addr,
	input  logic [`WORD_W-1:0]      i_wr_data,
	input  logic                    i_i_hit,
	input  logic                    i_d_hit,
	input  logic                    i_dirty,      // Victim valid and dirty
	input  logic [`TAG_W-1:0]       i_victim_tag,
	input  logic [`LINE_W-1:0]      i_d_line,     // Line at data index
	input  logic [`LINE_W-1:0]      i_m_line,     // Line read from memory
	input  logic                    i_mem_rdy,    // One-cycle completion
	output logic                    o_i_we,
	output logic [`LINE_W-1:0]      o_i_fill,
	output logic                    o_d_we,
	output logic [`LINE_W-1:0]      o_d_fill,
	output logic                    o_d_dirty_in,
	output logic                    o_m_re,
	output logic                    o_m_we,
	output logic [`LINE_ADDR_W-1:0] o_m_addr,
	output logic [`LINE_W-1:0]      o_m_data,
	output logic                    o_rdy         // Access complete this cycle
);

	localparam logic [1:0] START        = 2'd0;
	localparam logic [1:0] SERVICE_MISS = 2'd1;
	localparam logic [1:0] WRITE_BACK   = 2'd2;

	logic [1:0]  state, next_state;
	cache_addr_u i_a, d_a, wb_a;
	logic        d_miss, i_miss;

	assign i_a    = i_i_addr;
	assign d_a    = i_d_addr;
	assign wb_a   = {i_victim_tag, d_a.f.index, {`OFFSET_W{1'b0}}}; // Victim's home line
	assign d_miss = i_d_acc & ~i_d_hit;
	assign i_miss = i_i_acc & ~i_i_hit;

	// Drop one store word into its slot of a line
	function automatic logic [`LINE_W-1:0] merge_word(
		input logic [`LINE_W-1:0]   line,
		input logic [`WORD_W-1:0]   word,
		input logic [`OFFSET_W-1:0] off
	);
		logic [`LINE_W-1:0] merged;
		merged = line;
		merged[off * `WORD_W +: `WORD_W] = word;
		return merged;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= START;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state   = state;
		o_i_we       = 1'b0;
		o_i_fill     = i_m_line;
		o_d_we       = 1'b0;
		o_d_fill     = i_m_line;
		o_d_dirty_in = 1'b0;
		o_m_re       = 1'b0;
		o_m_we       = 1'b0;
		o_m_addr     = '0;
		o_m_data     = '0;
		o_rdy        = 1'b0;
		case (state)
			START: begin
				if (d_miss) begin // Data side served first
					if (i_dirty) begin
						o_m_we     = 1'b1;
						o_m_addr   = wb_a.m.line;
						o_m_data   = i_d_line;
						next_state = WRITE_BACK;
					end else begin
						o_m_re     = 1'b1;
						o_m_addr   = d_a.m.line;
						next_state = SERVICE_MISS;
					end
				end else if (i_miss) begin
					o_m_re     = 1'b1;
					o_m_addr   = i_a.m.line;
					next_state = SERVICE_MISS;
				end else begin
					o_rdy = 1'b1; // All active sides hit
					if (i_d_acc && i_write) begin // Store hit, merge into cached line
						o_d_we       = 1'b1;
						o_d_fill     = merge_word(i_d_line, i_wr_data, d_a.f.offset);
						o_d_dirty_in = 1'b1;
					end
				end
			end
			SERVICE_MISS: begin
				o_m_re   = 1'b1; // Held through the completion cycle
				o_m_addr = d_miss ? d_a.m.line : i_a.m.line;
				if (i_mem_rdy) begin
					if (d_miss) begin
						o_d_we = 1'b1;
						if (i_write) begin // Fill then merge
							o_d_fill     = merge_word(i_m_line, i_wr_data, d_a.f.offset);
							o_d_dirty_in = 1'b1;
						end
					end else begin
						o_i_we = 1'b1;
					end
					next_state = START; // Hits next cycle
				end
			end
			WRITE_BACK: begin
				o_m_we   = 1'b1;
				o_m_addr = wb_a.m.line;
				o_m_data = i_d_line; // Victim line unchanged until refill
				if (i_mem_rdy) begin
					next_state = SERVICE_MISS;
				end
			end
			default: begin
				next_state = START;
			end
		endcase
	end

	// Request must not move before memory answers
	a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(o_m_re || o_m_we) && !i_mem_rdy |=>
		$stable(o_m_re) && $stable(o_m_we) && $stable(o_m_addr) && $stable(o_m_data));

	// Refills only land after a read held for the full memory latency
	a_fill_rdy: assert property (@(posedge clk) disable iff (!rst_n)
		(o_i_we || (o_d_we && !o_rdy)) |-> $past(o_m_re, `MEM_LATENCY));

endmodule

// File: common/cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// Address split is tag | index | offset, all word addressed
`define ADDR_W      16 // Word address width
`define WORD_W      16 // Processor word
`define LINE_W      64 // Four words per line
`define TAG_W       8  // Upper address bits
`define INDEX_W     6  // 64 lines per cache
`define OFFSET_W    2  // Word within line

`define LINE_ADDR_W 14 // Tag and index together

// Cycles a memory request is held before completion
`define MEM_LATENCY 4

`endif

// File: common/cache_pkg.sv
`include "cache_defines.svh"

package cache_pkg;

	// One address word, decoded either for the caches or for memory
	typedef union packed {
		struct packed {
			logic [`TAG_W-1:0]    tag;    // Compared against stored tag
			logic [`INDEX_W-1:0]  index;  // Selects cache line
			logic [`OFFSET_W-1:0] offset; // Selects word in line
		} f;
		struct packed {
			logic [`LINE_ADDR_W-1:0] line;   // Line number in unified memory
			logic [`OFFSET_W-1:0]    offset; // Unused by memory
		} m;
	} cache_addr_u;

endpackage

// File: compile.f
+incdir+common
common/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/unified_mem.sv
cache_controller/cache_controller.sv
hdl/mem_hierarchy.sv
verif/tb_mem_hierarchy.sv

// File: hdl/dcache.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module dcache
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ADDR_W-1:0] i_addr,       // Data address
	input  logic               i_we,         // Store strobe, fill or merge
	input  logic [`LINE_W-1:0] i_fill,       // Whole line to store
	input  logic               i_dirty_in,   // Dirty bit to store with line
	output logic               o_hit,
	output logic               o_dirty,      // Line at index needs write back
	output logic [`TAG_W-1:0]  o_victim_tag, // Tag currently at index
	output logic [`LINE_W-1:0] o_line,       // Line currently at index
	output logic [`WORD_W-1:0] o_word        // Load data
);

	localparam int LINES = 1 << `INDEX_W;

	logic [`LINE_W-1:0] lines [LINES];
	logic [`TAG_W-1:0]  tags  [LINES];
	logic [LINES-1:0]   valid;
	logic [LINES-1:0]   dirty;
	cache_addr_u        a;

	assign a = i_addr;

	// Everything below reads the line at the request index
	assign o_line       = lines[a.f.index];
	assign o_victim_tag = tags[a.f.index];
	assign o_hit        = valid[a.f.index] && (o_victim_tag == a.f.tag);
	assign o_dirty      = valid[a.f.index] && dirty[a.f.index];
	assign o_word       = o_line[a.f.offset * `WORD_W +: `WORD_W];

	// Status bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			dirty <= '0;
		end else if (i_we) begin
			valid[a.f.index] <= 1'b1;
			dirty[a.f.index] <= i_dirty_in; // Clean on plain refill
		end
	end

	// Payload store, no reset
	always_ff @(posedge clk) begin
		if (i_we) begin
			lines[a.f.index] <= i_fill;
			tags[a.f.index]  <= a.f.tag;
		end
	end

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module icache
	import cache_pkg::*;
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic [`ADDR_W-1:0] i_addr,  // Fetch address
	input  logic               i_we,    // Refill strobe
	input  logic [`LINE_W-1:0] i_fill,  // Refill line from memory
	output logic               o_hit,
	output logic [`WORD_W-1:0] o_word   // Fetched instruction
);

	localparam int LINES = 1 << `INDEX_W;

	logic [`LINE_W-1:0] lines [LINES];
	logic [`TAG_W-1:0]  tags  [LINES];
	logic [LINES-1:0]   valid;
	cache_addr_u        a;
	logic [`LINE_W-1:0] line_q;

	assign a      = i_addr;
	assign line_q = lines[a.f.index];
	assign o_hit  = valid[a.f.index] && (tags[a.f.index] == a.f.tag);
	assign o_word = line_q[a.f.offset * `WORD_W +: `WORD_W]; // Word by offset

	// Valid bits only, cleared on reset
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
		end else if (i_we) begin
			valid[a.f.index] <= 1'b1;
		end
	end

	// Line and tag store
	always_ff @(posedge clk) begin
		if (i_we) begin
			lines[a.f.index] <= i_fill;
			tags[a.f.index]  <= a.f.tag; // Tag of the line being fetched
		end
	end

	// Controller only refills on a miss
	a_no_fill_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
		i_we |-> !o_hit);

endmodule

// File: hdl/mem_hierarchy.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module mem_hierarchy (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_i_acc,   // Instruction fetch request
	input  logic [`ADDR_W-1:0] i_i_addr,
	input  logic               i_d_acc,   // Data access request
	input  logic [`ADDR_W-1:0] i_d_addr,
	input  logic               i_write,   // Store when set, load otherwise
	input  logic [`WORD_W-1:0] i_wr_data,
	output logic               o_rdy,     // Both requests done
	output logic [`WORD_W-1:0] o_instr,
	output logic [`WORD_W-1:0] o_rd_data
);

	// Cache to controller
	logic                    i_hit, d_hit, d_dirty;
	logic [`TAG_W-1:0]       victim_tag;
	logic [`LINE_W-1:0]      d_line;

	// Controller to caches
	logic                    i_we, d_we, d_dirty_in;
	logic [`LINE_W-1:0]      i_fill, d_fill;

	// Controller to memory
	logic                    m_re, m_we, mem_rdy;
	logic [`LINE_ADDR_W-1:0] m_addr;
	logic [`LINE_W-1:0]      m_data, m_line;

	icache u_icache (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_addr (i_i_addr),
		.i_we   (i_we),
		.i_fill (i_fill),
		.o_hit  (i_hit),
		.o_word (o_instr)
	);

	dcache u_dcache (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_addr       (i_d_addr),
		.i_we         (d_we),
		.i_fill       (d_fill),
		.i_dirty_in   (d_dirty_in),
		.o_hit        (d_hit),
		.o_dirty      (d_dirty),
		.o_victim_tag (victim_tag),
		.o_line       (d_line),
		.o_word       (o_rd_data)
	);

	cache_controller u_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.i_i_acc      (i_i_acc),
		.i_d_acc      (i_d_acc),
		.i_write      (i_write),
		.i_i_addr     (i_i_addr),
		.i_d_addr     (i_d_addr),
		.i_wr_data    (i_wr_data),
		.i_i_hit      (i_hit),
		.i_d_hit      (d_hit),
		.i_dirty      (d_dirty),
		.i_victim_tag (victim_tag),
		.i_d_line     (d_line),
		.i_m_line     (m_line),
		.i_mem_rdy    (mem_rdy),
		.o_i_we       (i_we),
		.o_i_fill     (i_fill),
		.o_d_we       (d_we),
		.o_d_fill     (d_fill),
		.o_d_dirty_in (d_dirty_in),
		.o_m_re       (m_re),
		.o_m_we       (m_we),
		.o_m_addr     (m_addr),
		.o_m_data     (m_data),
		.o_rdy        (o_rdy)
	);

	unified_mem u_mem (
		.clk    (clk),
		.rst_n  (rst_n),
		.i_re   (m_re),
		.i_we   (m_we),
		.i_addr (m_addr),
		.i_data (m_data),
		.o_rdy  (mem_rdy),
		.o_line (m_line)
	);

endmodule

// File: hdl/unified_mem.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module unified_mem (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_re,   // Line read request, held
	input  logic                    i_we,   // Line write request, held
	input  logic [`LINE_ADDR_W-1:0] i_addr,
	input  logic [`LINE_W-1:0]      i_data,
	output logic                    o_rdy,  // One-cycle completion pulse
	output logic [`LINE_W-1:0]      o_line  // Valid while o_rdy high
);

	localparam int LINES = 1 << `LINE_ADDR_W;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`MEM_LATENCY - 1);

	logic [`LINE_W-1:0] mem [LINES];
	logic [CNT_W-1:0]   cnt;
	logic               req, done;

	assign req  = i_re | i_we;
	assign done = req && !o_rdy && (cnt == LAST); // Last held cycle

	// Boot image, every word holds its own word address
	initial begin
		for (int i = 0; i < LINES; i++) begin
			for (int k = 0; k < 4; k++) begin
				mem[i][k * `WORD_W +: `WORD_W] = `WORD_W'((i << `OFFSET_W) + k);
			end
		end
	end

	// Latency count
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			o_rdy <= 1'b0;
		end else if (o_rdy) begin // Completion cycle, start over
			cnt   <= '0;
			o_rdy <= 1'b0;
		end else if (done) begin
			cnt   <= '0;
			o_rdy <= 1'b1;
		end else if (req) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0; // Idle
		end
	end

	always_ff @(posedge clk) begin
		if (done) begin
			if (i_we) begin
				mem[i_addr] <= i_data; // Commit write back
			end else begin
				o_line <= mem[i_addr];
			end
		end
	end

	a_one_op: assert property (@(posedge clk) disable iff (!rst_n)
		!(i_re && i_we));

endmodule

// File: verif/tb_mem_hierarchy.sv
`timescale 1ns/1ps
`include "cache_defines.svh"

module tb_mem_hierarchy
	import cache_pkg::*;
();

	localparam int TIMEOUT = 4 * `MEM_LATENCY + 8; // Cycles allowed per access
	localparam int N_TXN   = 2000;                 // Random accesses in the run

	logic               clk;
	logic               rst_n;
	logic               i_i_acc;
	logic [`ADDR_W-1:0] i_i_addr;
	logic               i_d_acc;
	logic [`ADDR_W-1:0] i_d_addr;
	logic               i_write;
	logic [`WORD_W-1:0] i_wr_data;
	logic               o_rdy;
	logic [`WORD_W-1:0] o_instr;
	logic [`WORD_W-1:0] o_rd_data;

	logic [`WORD_W-1:0] model [1 << `ADDR_W]; // Word view of the whole memory
	logic [15:0]        lfsr;                 // Random state

	mem_hierarchy uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_i_acc   (i_i_acc),
		.i_i_addr  (i_i_addr),
		.i_d_acc   (i_d_acc),
		.i_d_addr  (i_d_addr),
		.i_write   (i_write),
		.i_wr_data (i_wr_data),
		.o_rdy     (o_rdy),
		.o_instr   (o_instr),
		.o_rd_data (o_rd_data)
	);

	always #5 clk = ~clk; // 10 ns period

	// One Galois step, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hb400 : 16'h0000);
	endfunction

	// Collect n bits, one step per bit
	task automatic draw_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[14:0], lfsr[0]};
		end
	endtask

	// Narrow pool: 2 tag bits, 3 index bits, 2 offset bits
	task automatic draw_addr(input logic upper, output logic [`ADDR_W-1:0] addr);
		cache_addr_u a;
		logic [15:0] t;
		logic [15:0] x;
		logic [15:0] o;
		draw_bits(2, t);
		draw_bits(3, x);
		draw_bits(2, o);
		a          = '0;
		a.f.tag    = {upper, 5'b0, t[1:0]}; // Bit 15 splits fetch from data space
		a.f.index  = {3'b0, x[2:0]};
		a.f.offset = o[1:0];
		addr       = a;
	endtask

	task automatic compare_word(input string name, input logic [15:0] exp,
		input logic [15:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// Hold one request until o_rdy, then check both read ports
	task automatic run_access(input string name, input logic ia, input logic [15:0] ia_addr,
		input logic da, input logic [15:0] da_addr, input logic wr, input logic [15:0] wd);
		int cycles;
		@(negedge clk);
		i_i_acc   = ia;
		i_i_addr  = ia_addr;
		i_d_acc   = da;
		i_d_addr  = da_addr;
		i_write   = wr;
		i_wr_data = wd;
		cycles    = 0;
		#1; // Let the hit logic settle
		while (!o_rdy && cycles < TIMEOUT) begin
			@(negedge clk);
			#1;
			cycles++;
		end
		if (!o_rdy) begin
			$display("o_rdy never rose within %0d cycles during %s", TIMEOUT, name);
			$display("Errors found");
			$fatal(1);
		end else begin
			if (ia) begin
				compare_word({name, "_instr"}, ia_addr, o_instr); // Boot image word
			end
			if (da && !wr) begin
				compare_word(name, model[da_addr], o_rd_data);
			end
			@(posedge clk); // Access accepted, store lands here
			if (da && wr) begin
				model[da_addr] = wd;
			end
		end
	endtask

	// Data read whose first cycle must hit or miss, o_rdy shows which
	task automatic check_first_cycle(input string name, input logic [15:0] addr,
		input logic exp_rdy);
		@(negedge clk);
		i_i_acc  = 1'b0;
		i_d_acc  = 1'b1;
		i_d_addr = addr;
		i_write  = 1'b0;
		#1;
		compare_word(name, {15'b0, exp_rdy}, {15'b0, o_rdy});
	endtask

	task automatic apply_reset();
		@(negedge clk);
		rst_n   = 1'b0;
		i_i_acc = 1'b0;
		i_d_acc = 1'b0;
		i_write = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	endtask

	// Foreign tag on each pool index pushes dirty lines to memory
	task automatic flush_pool();
		cache_addr_u a;
		for (int x = 0; x < 8; x++) begin
			a         = '0;
			a.f.tag   = 8'h10; // Outside the random tag pool
			a.f.index = x[5:0];
			run_access("flush", 1'b0, 16'h0000, 1'b1, a, 1'b0, 16'h0000);
		end
	endtask

	initial begin
		logic [15:0] kind;
		logic [15:0] rw;
		logic [15:0] wd;
		logic [15:0] ia;
		logic [15:0] da;
		logic        i_on;
		logic        d_on;
		string       phase;
		clk       = 1'b0;
		rst_n     = 1'b0;
		i_i_acc   = 1'b0;
		i_i_addr  = '0;
		i_d_acc   = 1'b0;
		i_d_addr  = '0;
		i_write   = 1'b0;
		i_wr_data = '0;
		lfsr      = 16'd71;
		phase     = "rand_rd";
		for (int i = 0; i < (1 << `ADDR_W); i++) begin
			model[i] = i[15:0]; // Preload pattern
		end
		apply_reset();

		// Dirty line evicted by a tag conflict, then read back
		run_access("evict_wr", 1'b0, 16'h0000, 1'b1, 16'h0105, 1'b1, 16'hbeef);
		run_access("evict_conflict", 1'b0, 16'h0000, 1'b1, 16'h0205, 1'b0, 16'h0000);
		run_access("evict_rd", 1'b0, 16'h0000, 1'b1, 16'h0105, 1'b0, 16'h0000);

		for (int n = 0; n < N_TXN; n++) begin
			if (n == N_TXN / 2) begin // Mid-run reset, memory keeps its data
				flush_pool();
				apply_reset();
				check_first_cycle("post_rst_miss", 16'h1000, 1'b0); // Flushed line now invalid
				run_access("post_rst_miss", 1'b0, 16'h0000, 1'b1, 16'h1000, 1'b0, 16'h0000);
				phase = "post_rst_rd";
			end
			draw_bits(2, kind);
			draw_bits(1, rw);
			draw_bits(16, wd);
			draw_addr(1'b1, ia);
			draw_addr(1'b0, da);
			i_on = (kind[1:0] != 2'd1); // 0 fetch, 1 data, 2 and 3 both
			d_on = (kind[1:0] != 2'd0);
			run_access(phase, i_on, ia, d_on, da, d_on & rw[0], wd);
			if (d_on && rw[0]) begin
				check_first_cycle("raw_hit", da, 1'b1); // Written line stays resident
				run_access("raw", 1'b0, 16'h0000, 1'b1, da, 1'b0, 16'h0000);
			end
		end
		$display("No errors");
		$finish;
	end

endmodule
